// ==== hw/exe_pkg.sv ====
package exe_pkg;

    localparam int XLEN = 64;
    localparam int NUM_REGS = 32;
    localparam int DIV_STEPS = 64;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // codes above REMUW are illegal
    typedef enum logic [4:0] {
        OP_NOP,
        SLL, SRL, SRA,
        ADD, SUB,
        XOR, OR, AND,
        SLT, SLTU,
        SLLW, SRLW, SRAW, ADDW, SUBW,
        MUL, MULH, MULHSU, MULW,
        DIV, DIVU, REM, REMU,
        DIVW, DIVUW, REMW, REMUW
    } exe_op_e;

    typedef enum logic [1:0] {
        SRC_R_R,
        SRC_R_I,
        SRC_PC_I
    } src_sel_e;

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_MUL,
        MD_DIV,
        MD_DONE
    } muldiv_state_e;

    typedef struct packed {
        exe_op_e  op;
        src_sel_e src_sel;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;
        xlen_t    pc;
    } issue_t;

    typedef struct packed {
        exe_op_e  op;
        reg_idx_t rd;
        xlen_t    src1;
        xlen_t    src2;
    } exec_req_t;

    typedef struct packed {
        reg_idx_t rd;
        xlen_t    data;
    } wb_t;

    // W-form results widen from bit 31
    function automatic xlen_t sext_word(word_t w);
        return {{(XLEN - 32){w[31]}}, w};
    endfunction

endpackage

// ==== hw/exe_issue.sv ====
module exe_issue (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  exe_pkg::issue_t   in,
    output exe_pkg::reg_idx_t rs1,
    output exe_pkg::reg_idx_t rs2,
    input  exe_pkg::xlen_t    rdata1,
    input  exe_pkg::xlen_t    rdata2,
    output logic              alu_valid,
    input  logic              alu_ready,
    output exe_pkg::exec_req_t alu_req,
    output logic              md_valid,
    input  logic              md_ready,
    output exe_pkg::exec_req_t md_req,
    input  exe_pkg::reg_idx_t md_busy_rd,
    input  logic              md_busy,
    output logic              illegal
);
    import exe_pkg::*;

    logic      is_alu;
    logic      is_md;
    logic      is_bad;
    logic      reads_rs1;
    logic      reads_rs2;
    logic      rd_hazard;
    logic      alu_go;
    logic      md_go;
    exec_req_t req;

    assign rs1 = in.rs1;
    assign rs2 = in.rs2;

    always_comb begin
        is_alu = in.op inside {SLL, SRL, SRA, ADD, SUB, XOR, OR, AND, SLT, SLTU,
                               SLLW, SRLW, SRAW, ADDW, SUBW};
        is_md = in.op inside {MUL, MULH, MULHSU, MULW, DIV, DIVU, REM, REMU,
                              DIVW, DIVUW, REMW, REMUW};
        is_bad = !is_alu && !is_md && (in.op != OP_NOP);
    end

    // operand select
    always_comb begin
        req.op = in.op;
        req.rd = in.rd;
        case (in.src_sel)
            SRC_R_R: begin
                req.src1 = rdata1;
                req.src2 = rdata2;
            end
            SRC_R_I: begin
                req.src1 = rdata1;
                req.src2 = in.imm;
            end
            SRC_PC_I: begin
                req.src1 = in.pc;
                req.src2 = in.imm;
            end
            default: begin
                req.src1 = '0;
                req.src2 = '0;
            end
        endcase
    end

    assign reads_rs1 = (in.src_sel == SRC_R_R) || (in.src_sel == SRC_R_I);
    assign reads_rs2 = (in.src_sel == SRC_R_R);

    // RAW or WAW against the rd still owned by the divider
    assign rd_hazard = md_busy && ((reads_rs1 && in.rs1 == md_busy_rd) ||
                                   (reads_rs2 && in.rs2 == md_busy_rd) ||
                                   (in.rd == md_busy_rd));

    assign alu_go = is_alu && !rd_hazard;
    // a result parked in the ALU is not in the register file yet
    assign md_go = is_md && !md_busy && alu_ready;

    assign alu_valid = in_valid && alu_go;
    assign md_valid = in_valid && md_go;
    assign alu_req = req;
    assign md_req = req;

    // nop and illegal codes are swallowed at once
    assign in_ready = is_alu ? (alu_go && alu_ready) :
                      is_md  ? (md_go && md_ready) : 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            illegal <= 1'b0;
        end else begin
            illegal <= in_valid && in_ready && is_bad;
        end
    end

endmodule

// ==== hw/exe_regfile.sv ====
module exe_regfile (
    input  logic              clk,
    input  logic              rst,
    input  exe_pkg::reg_idx_t rs1,
    input  exe_pkg::reg_idx_t rs2,
    output exe_pkg::xlen_t    rdata1,
    output exe_pkg::xlen_t    rdata2,
    input  logic              we,
    input  exe_pkg::wb_t      wdata
);
    import exe_pkg::*;

    xlen_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wdata.rd != '0) begin
            regs[wdata.rd] <= wdata.data;
        end
    end

    // x0 is hardwired
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hw/exe_alu.sv ====
module exe_alu (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    output logic               req_ready,
    input  exe_pkg::exec_req_t req,
    output logic               wb_valid,
    input  logic               wb_ready,
    output exe_pkg::wb_t       wb
);
    import exe_pkg::*;

    xlen_t a;
    xlen_t b;
    xlen_t res;
    logic  valid_q;
    wb_t   wb_q;

    assign a = req.src1;
    assign b = req.src2;

    always_comb begin
        case (req.op)
            SLL: begin
                res = a << b[5:0];
            end
            SRL: begin
                res = a >> b[5:0];
            end
            SRA: begin
                res = $signed(a) >>> b[5:0];
            end
            ADD: begin
                res = a + b;
            end
            SUB: begin
                res = a - b;
            end
            XOR: begin
                res = a ^ b;
            end
            OR: begin
                res = a | b;
            end
            AND: begin
                res = a & b;
            end
            SLT: begin
                res = {{(XLEN - 1){1'b0}}, $signed(a) < $signed(b)};
            end
            SLTU: begin
                res = {{(XLEN - 1){1'b0}}, a < b};
            end
            // word forms use a 5-bit shift amount
            SLLW: begin
                res = sext_word(a[31:0] << b[4:0]);
            end
            SRLW: begin
                res = sext_word(a[31:0] >> b[4:0]);
            end
            SRAW: begin
                res = sext_word($signed(a[31:0]) >>> b[4:0]);
            end
            ADDW: begin
                res = sext_word(a[31:0] + b[31:0]);
            end
            SUBW: begin
                res = sext_word(a[31:0] - b[31:0]);
            end
            default: begin
                res = '0;
            end
        endcase
    end

    // one-entry result buffer, refilled only once empty
    assign req_ready = !valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (req_valid && req_ready) begin
            valid_q <= 1'b1;
        end else if (wb_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            wb_q.rd <= req.rd;
            wb_q.data <= res;
        end
    end

    assign wb_valid = valid_q;
    assign wb = wb_q;

endmodule

// ==== hw/exe_muldiv.sv ====
module exe_muldiv (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    output logic               req_ready,
    input  exe_pkg::exec_req_t req,
    output logic               wb_valid,
    input  logic               wb_ready,
    output exe_pkg::wb_t       wb,
    output logic               busy,
    output exe_pkg::reg_idx_t  busy_rd
);
    import exe_pkg::*;

    muldiv_state_e          state;
    logic [DIV_CNT_W-1:0]   cnt_q;
    exe_op_e                op_q;
    reg_idx_t               rd_q;
    xlen_t                  opa_q;
    xlen_t                  opb_q;
    xlen_t                  rem_q;
    xlen_t                  res_q;
    logic                   quo_neg;
    logic                   rem_neg;
    logic                   is_mul;
    logic                   is_signed;
    logic                   a_neg;
    logic                   b_neg;
    logic                   b_zero;
    xlen_t                  a_ext;
    xlen_t                  b_ext;
    xlen_t                  a_mag;
    xlen_t                  b_mag;
    xlen_t                  zero_res;
    logic [2*XLEN-1:0]      mul_a;
    logic [2*XLEN-1:0]      mul_b;
    logic [2*XLEN-1:0]      prod;
    xlen_t                  mul_res;
    logic [XLEN:0]          shift;
    logic [XLEN:0]          diff;
    xlen_t                  quo_fix;
    xlen_t                  rem_fix;
    xlen_t                  div_res;

    function automatic logic op_is_w(exe_op_e op);
        return op inside {MULW, DIVW, DIVUW, REMW, REMUW};
    endfunction

    function automatic logic op_is_rem(exe_op_e op);
        return op inside {REM, REMU, REMW, REMUW};
    endfunction

    function automatic xlen_t fit_w(exe_op_e op, xlen_t v);
        return op_is_w(op) ? sext_word(v[31:0]) : v;
    endfunction

    // request decode, divide operands reduced to magnitudes
    always_comb begin
        is_mul = req.op inside {MUL, MULH, MULHSU, MULW};
        is_signed = req.op inside {DIV, REM, DIVW, REMW};
        if (op_is_w(req.op)) begin
            a_ext = is_signed ? sext_word(req.src1[31:0]) : {32'b0, req.src1[31:0]};
            b_ext = is_signed ? sext_word(req.src2[31:0]) : {32'b0, req.src2[31:0]};
        end else begin
            a_ext = req.src1;
            b_ext = req.src2;
        end
        a_neg = is_signed && a_ext[XLEN-1];
        b_neg = is_signed && b_ext[XLEN-1];
        a_mag = a_neg ? -a_ext : a_ext;
        b_mag = b_neg ? -b_ext : b_ext;
        b_zero = (b_ext == '0);
        zero_res = op_is_rem(req.op) ? a_ext : '1;
    end

    // single multiplier, operands widened per op
    always_comb begin
        mul_a = {{XLEN{opa_q[XLEN-1] && (op_q == MULH || op_q == MULHSU)}}, opa_q};
        mul_b = {{XLEN{opb_q[XLEN-1] && (op_q == MULH)}}, opb_q};
        prod = mul_a * mul_b;
        case (op_q)
            MULH, MULHSU: mul_res = prod[2*XLEN-1:XLEN];
            MULW: mul_res = sext_word(prod[31:0]);
            default: mul_res = prod[XLEN-1:0];
        endcase
    end

    // restoring step; opa_q shifts dividend out and quotient in
    always_comb begin
        shift = {rem_q, opa_q[XLEN-1]};
        diff = shift - {1'b0, opb_q};
        quo_fix = quo_neg ? -opa_q : opa_q;
        rem_fix = rem_neg ? -rem_q : rem_q;
        div_res = fit_w(op_q, op_is_rem(op_q) ? rem_fix : quo_fix);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MD_IDLE;
            cnt_q <= '0;
        end else begin
            case (state)
                MD_IDLE: begin
                    if (req_valid) begin
                        cnt_q <= '0;
                        if (is_mul) begin
                            state <= MD_MUL;
                        end else if (b_zero) begin
                            state <= MD_DONE;
                        end else begin
                            state <= MD_DIV;
                        end
                    end
                end
                MD_MUL: begin
                    state <= MD_DONE;
                end
                MD_DIV: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == DIV_STEPS) begin
                        state <= MD_DONE;
                    end
                end
                MD_DONE: begin
                    if (wb_ready) begin
                        state <= MD_IDLE;
                    end
                end
                default: begin
                    state <= MD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MD_IDLE && req_valid) begin
            op_q <= req.op;
            rd_q <= req.rd;
            opa_q <= is_mul ? req.src1 : a_mag;
            opb_q <= is_mul ? req.src2 : b_mag;
            rem_q <= '0;
            quo_neg <= a_neg ^ b_neg;
            rem_neg <= a_neg;
            // only kept when the divisor is zero
            res_q <= fit_w(req.op, zero_res);
        end else if (state == MD_MUL) begin
            res_q <= mul_res;
        end else if (state == MD_DIV) begin
            if (cnt_q == DIV_STEPS) begin
                res_q <= div_res;
            end else begin
                opa_q <= {opa_q[XLEN-2:0], ~diff[XLEN]};
                rem_q <= diff[XLEN] ? shift[XLEN-1:0] : diff[XLEN-1:0];
            end
        end
    end

    assign req_ready = (state == MD_IDLE);
    assign wb_valid = (state == MD_DONE);
    assign wb = '{rd: rd_q, data: res_q};
    assign busy = (state != MD_IDLE);
    assign busy_rd = rd_q;

endmodule

// ==== hw/exe_wb_arbiter.sv ====
module exe_wb_arbiter (
    input  logic         md_valid,
    output logic         md_ready,
    input  exe_pkg::wb_t md_wb,
    input  logic         alu_valid,
    output logic         alu_ready,
    input  exe_pkg::wb_t alu_wb,
    output logic         we,
    output exe_pkg::wb_t wdata
);

    // write port never stalls, so the divider always gets through
    assign md_ready = 1'b1;

    // ALU waits whenever the multiply/divide unit writes
    assign alu_ready = !md_valid;

    assign we = md_valid || alu_valid;
    assign wdata = md_valid ? md_wb : alu_wb;

endmodule

// ==== hw/exe_top.sv ====
module exe_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    output logic            in_ready,
    input  exe_pkg::issue_t in,
    output logic            wb_valid,
    output exe_pkg::wb_t    wb,
    output logic            illegal
);
    import exe_pkg::*;

    reg_idx_t  rs1;
    reg_idx_t  rs2;
    xlen_t     rdata1;
    xlen_t     rdata2;
    logic      alu_valid;
    logic      alu_ready;
    exec_req_t alu_req;
    logic      md_valid;
    logic      md_ready;
    exec_req_t md_req;
    logic      md_busy;
    reg_idx_t  md_busy_rd;
    logic      alu_wb_valid;
    logic      alu_wb_ready;
    wb_t       alu_wb;
    logic      md_wb_valid;
    logic      md_wb_ready;
    wb_t       md_wb;

    exe_issue exe_issue_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in         (in),
        .rs1        (rs1),
        .rs2        (rs2),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .alu_valid  (alu_valid),
        .alu_ready  (alu_ready),
        .alu_req    (alu_req),
        .md_valid   (md_valid),
        .md_ready   (md_ready),
        .md_req     (md_req),
        .md_busy_rd (md_busy_rd),
        .md_busy    (md_busy),
        .illegal    (illegal)
    );

    exe_regfile exe_regfile_inst (
        .clk    (clk),
        .rst    (rst),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (wb_valid),
        .wdata  (wb)
    );

    exe_alu exe_alu_inst (
        .clk       (clk),
        .rst       (rst),
        .req_valid (alu_valid),
        .req_ready (alu_ready),
        .req       (alu_req),
        .wb_valid  (alu_wb_valid),
        .wb_ready  (alu_wb_ready),
        .wb        (alu_wb)
    );

    exe_muldiv exe_muldiv_inst (
        .clk       (clk),
        .rst       (rst),
        .req_valid (md_valid),
        .req_ready (md_ready),
        .req       (md_req),
        .wb_valid  (md_wb_valid),
        .wb_ready  (md_wb_ready),
        .wb        (md_wb),
        .busy      (md_busy),
        .busy_rd   (md_busy_rd)
    );

    exe_wb_arbiter exe_wb_arbiter_inst (
        .md_valid  (md_wb_valid),
        .md_ready  (md_wb_ready),
        .md_wb     (md_wb),
        .alu_valid (alu_wb_valid),
        .alu_ready (alu_wb_ready),
        .alu_wb    (alu_wb),
        .we        (wb_valid),
        .wdata     (wb)
    );

endmodule

// ==== verif/exe_properties.sv ====
module exe_properties (
    input logic            clk,
    input logic            rst,
    input logic            in_valid,
    input logic            in_ready,
    input exe_pkg::issue_t in,
    input logic            alu_wb_valid,
    input logic            alu_wb_ready,
    input exe_pkg::wb_t    alu_wb,
    input logic            md_wb_valid,
    input logic            md_wb_ready,
    input logic            wb_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    in_hold: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in))
        else $error("issue valid or payload changed before transfer");

    alu_wb_hold: assert property (@(posedge clk) disable iff (rst)
        alu_wb_valid && !alu_wb_ready |=> alu_wb_valid && $stable(alu_wb))
        else $error("ALU result changed while stalled");

    // registers are cleared on the reset edge
    wb_quiet_in_reset: assert property (@(posedge clk)
        rst |=> !wb_valid)
        else $error("write port active during reset");

    one_grant: assert property (@(posedge clk) disable iff (rst)
        !(alu_wb_valid && alu_wb_ready && md_wb_valid && md_wb_ready))
        else $error("both units granted the write port");

endmodule

// ==== verif/exe_tb.sv ====
module exe_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import exe_pkg::*;

    typedef struct packed {
        issue_t   ins;
        logic     writes;
        reg_idx_t rd;
        xlen_t    val;
    } entry_t;

    logic   clk;
    logic   rst;
    logic   in_valid;
    logic   in_ready;
    issue_t in;
    logic   wb_valid;
    wb_t    wb;
    logic   illegal;

    entry_t              table_q[$];
    xlen_t               expect_val[NUM_REGS];
    logic [NUM_REGS-1:0] pending = '0;
    int                  errors = 0;
    int                  illegal_seen = 0;
    int                  illegal_expected = 0;
    int                  cycles = 0;
    int                  limit = 0;
    xlen_t               ra;
    xlen_t               rb;
    xlen_t               quo;
    issue_t              ins;

    exe_top exe_top_inst (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in       (in),
        .wb_valid (wb_valid),
        .wb       (wb),
        .illegal  (illegal)
    );

    bind exe_top exe_properties exe_properties_inst (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in           (in),
        .alu_wb_valid (alu_wb_valid),
        .alu_wb_ready (alu_wb_ready),
        .alu_wb       (alu_wb),
        .md_wb_valid  (md_wb_valid),
        .md_wb_ready  (md_wb_ready),
        .wb_valid     (wb_valid)
    );

    always #10 clk = ~clk;

    function automatic issue_t make_issue(exe_op_e op, src_sel_e sel, reg_idx_t rd,
                                          reg_idx_t rs1, reg_idx_t rs2, xlen_t imm);
        issue_t i;
        i.op = op;
        i.src_sel = sel;
        i.rd = rd;
        i.rs1 = rs1;
        i.rs2 = rs2;
        i.imm = imm;
        i.pc = 64'h0;
        return i;
    endfunction

    task automatic push_entry(input issue_t i, input logic writes, input xlen_t val);
        entry_t e;
        e.ins = i;
        e.writes = writes;
        e.rd = i.rd;
        e.val = val;
        table_q.push_back(e);
    endtask

    task automatic reg_reg_entry(input exe_op_e op, input reg_idx_t rd, input reg_idx_t rs1,
                                 input reg_idx_t rs2, input xlen_t val);
        push_entry(make_issue(op, SRC_R_R, rd, rs1, rs2, 64'h0), 1'b1, val);
    endtask

    task automatic reg_imm_entry(input exe_op_e op, input reg_idx_t rd, input reg_idx_t rs1,
                                 input xlen_t imm, input xlen_t val);
        push_entry(make_issue(op, SRC_R_I, rd, rs1, 5'd0, imm), 1'b1, val);
    endtask

    // holds valid and payload until the DUT takes them
    task automatic drive_issue(input issue_t i);
        in_valid <= 1'b1;
        in <= i;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // writeback scoreboard, one expected value per rd
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if (!pending[wb.rd]) begin
                $display("unexpected register write to x%0d with %h at %0t",
                         wb.rd, wb.data, $time);
                errors++;
            end else if (wb.data !== expect_val[wb.rd]) begin
                $display("FAILED at %0t: x%0d written with %h, expected %h",
                         $time, wb.rd, wb.data, expect_val[wb.rd]);
                errors++;
            end
            pending[wb.rd] = 1'b0;
        end
        if (!rst && illegal) begin
            illegal_seen++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("run timed out after %0d cycles, writes still missing for %h",
                     cycles, pending);
            errors++;
            $display("errors: %0d, illegal pulses: %0d", errors, illegal_seen);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst <= 1'b1;
        in_valid <= 1'b0;
        in <= '0;

        void'($urandom(22));
        ra = {$urandom, $urandom};
        rb = {$urandom, $urandom} | 64'h1;
        quo = $signed(ra) / $signed(rb);

        // register loads through x0 + imm
        reg_imm_entry(ADD, 5'd1, 5'd0, 64'hFFFF_FFFF_FFFF_FFF8, 64'hFFFF_FFFF_FFFF_FFF8);
        reg_imm_entry(ADD, 5'd2, 5'd0, 64'h3, 64'h3);
        reg_imm_entry(ADD, 5'd3, 5'd0, 64'h7FFF_FFFF, 64'h7FFF_FFFF);
        reg_imm_entry(ADD, 5'd4, 5'd0, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);
        reg_imm_entry(ADD, 5'd5, 5'd0, 64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF);
        reg_imm_entry(ADD, 5'd6, 5'd0, ra, ra);
        reg_imm_entry(ADD, 5'd7, 5'd0, rb, rb);
        reg_reg_entry(SRA, 5'd8, 5'd1, 5'd2, 64'hFFFF_FFFF_FFFF_FFFF);
        reg_reg_entry(SRL, 5'd9, 5'd1, 5'd2, 64'h1FFF_FFFF_FFFF_FFFF);
        reg_reg_entry(SLT, 5'd10, 5'd1, 5'd2, 64'h1);
        reg_reg_entry(SLTU, 5'd11, 5'd1, 5'd2, 64'h0);
        ins = make_issue(ADD, SRC_PC_I, 5'd12, 5'd0, 5'd0, 64'h24);
        ins.pc = 64'h1000;
        push_entry(ins, 1'b1, 64'h1024);
        // word forms
        reg_reg_entry(ADDW, 5'd14, 5'd3, 5'd2, 64'hFFFF_FFFF_8000_0002);
        reg_reg_entry(SUBW, 5'd15, 5'd2, 5'd3, 64'hFFFF_FFFF_8000_0004);
        reg_imm_entry(SLLW, 5'd16, 5'd2, 64'h3F, 64'hFFFF_FFFF_8000_0000);
        reg_imm_entry(SRAW, 5'd17, 5'd14, 64'h4, 64'hFFFF_FFFF_F800_0000);
        reg_reg_entry(MUL, 5'd18, 5'd6, 5'd7, ra * rb);
        reg_reg_entry(MULH, 5'd19, 5'd4, 5'd4, 64'h4000_0000_0000_0000);
        reg_reg_entry(MULHSU, 5'd20, 5'd1, 5'd5, 64'hFFFF_FFFF_FFFF_FFF8);
        reg_imm_entry(MULW, 5'd21, 5'd3, 64'h2, 64'hFFFF_FFFF_FFFF_FFFE);
        // x13 is free to pass the divide, x30 must wait for x22
        reg_reg_entry(DIV, 5'd22, 5'd6, 5'd7, quo);
        reg_reg_entry(SUB, 5'd13, 5'd6, 5'd7, ra - rb);
        reg_reg_entry(ADD, 5'd30, 5'd22, 5'd2, quo + 64'd3);
        reg_reg_entry(REMU, 5'd23, 5'd6, 5'd7, ra % rb);
        reg_reg_entry(DIV, 5'd24, 5'd1, 5'd0, 64'hFFFF_FFFF_FFFF_FFFF);
        reg_reg_entry(REM, 5'd25, 5'd6, 5'd0, ra);
        reg_reg_entry(DIV, 5'd26, 5'd4, 5'd5, 64'h8000_0000_0000_0000);
        reg_reg_entry(REM, 5'd27, 5'd4, 5'd5, 64'h0);
        reg_reg_entry(DIVW, 5'd28, 5'd1, 5'd2, 64'hFFFF_FFFF_FFFF_FFFE);
        reg_imm_entry(REMUW, 5'd29, 5'd5, 64'h7, 64'h3);
        reg_imm_entry(ADD, 5'd0, 5'd0, 64'h55, 64'h55);
        reg_reg_entry(ADD, 5'd31, 5'd0, 5'd2, 64'h3);
        push_entry(make_issue(exe_op_e'(5'd28), SRC_R_R, 5'd1, 5'd1, 5'd2, 64'h0), 1'b0, 64'h0);
        illegal_expected++;
        push_entry(make_issue(OP_NOP, SRC_R_R, 5'd2, 5'd1, 5'd2, 64'h0), 1'b0, 64'h0);

        limit = table_q.size() * (DIV_STEPS + 4) + 100;

        repeat (10) begin
            @(posedge clk);
        end
        rst <= 1'b0;

        foreach (table_q[k]) begin
            if (table_q[k].writes) begin
                pending[table_q[k].rd] = 1'b1;
                expect_val[table_q[k].rd] = table_q[k].val;
            end
            drive_issue(table_q[k].ins);
        end
        in_valid <= 1'b0;

        while (pending != '0) begin
            @(posedge clk);
        end
        // room for a late illegal pulse or a stray write
        repeat (4) begin
            @(posedge clk);
        end
        if (illegal_seen != illegal_expected) begin
            $display("FAILED at %0t: %0d illegal pulses, expected %0d",
                     $time, illegal_seen, illegal_expected);
            errors++;
        end

        $display("errors: %0d, illegal pulses: %0d", errors, illegal_seen);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hw/exe_pkg.sv
hw/exe_issue.sv
hw/exe_regfile.sv
hw/exe_alu.sv
hw/exe_muldiv.sv
hw/exe_wb_arbiter.sv
hw/exe_top.sv
verif/exe_properties.sv
verif/exe_tb.sv

// ==== Makefile ====
TOP := exe_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f files.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module exe_top -f files.f

clean:
	rm -rf obj_dir
